// File: filelist.f
src/vision_pkg.sv
src/pixel_ingress.sv
src/color_classifier.sv
src/target_accumulator.sv
src/report_egress.sv
src/target_finder_top.sv
tests/tb_target_finder.sv

// File: tests/target_trace.txt
# P r g b sof eol eof  : one input pixel, values in decimal
# R cls count x_min x_max y_min y_max  : one expected report, cls 0 orange .. 4 green
# Frame 1, three lines of 5, 3 and 6 pixels, window edges
P 8 2 5 1 0 0
P 11 3 8 0 0 0
P 10 0 6 0 0 0
P 3 7 10 0 0 0
P 4 10 4 0 1 0
P 12 3 10 0 0 0
P 15 5 0 0 0 0
P 7 6 7 0 1 0
P 0 15 0 0 0 0
P 15 0 15 0 0 0
P 6 1 10 0 0 0
P 0 0 15 0 0 0
P 5 12 2 0 0 0
P 9 4 3 0 1 1
R 0 3 0 5 0 2
R 1 2 0 1 1 2
R 2 2 2 2 0 2
R 3 2 3 3 0 2
R 4 2 0 4 0 2
# Frame 2, back to back, no pink pixel
P 13 4 1 1 0 0
P 8 2 9 0 0 0
P 2 3 12 0 1 0
P 1 11 0 0 0 0
P 14 8 8 0 1 1
R 0 1 0 0 0 0
R 2 1 1 1 0 0
R 3 1 2 2 0 0
R 4 1 0 0 1 1
# Frame 3, background only, gives no report
P 5 5 5 1 0 0
P 11 0 8 0 0 0
P 0 9 11 0 1 1

// File: tests/tb_target_finder.sv
`timescale 1ns/10ps
`default_nettype none

module tb_target_finder;

    import vision_pkg::*;

    localparam int PIX_DEPTH    = 8;   // Input FIFO depth, also upstream credits
    localparam int QUIET_CYCLES = 40;  // Must stay free of out_valid at the end

    logic           clk;
    logic           rst;
    logic           in_valid;
    logic           out_credit;
    pixel_beat_t    in_beat;
    logic           in_credit;
    logic           out_valid;
    target_report_t out_report;

    pixel_beat_t    pix_q[$];                // Stimulus from P lines
    target_report_t exp_q[$];                // Expected reports from R lines
    logic           trace_loaded  = 1'b0;
    int             trace_lines   = 0;
    int             reports_left  = 0;
    int             reports_done  = 0;
    int             pix_credits   = PIX_DEPTH;  // Upstream credit counter
    int             beats_sent    = 0;
    int             credit_pulses = 0;
    int             owed          = 0;       // Credits not yet returned downstream
    int unsigned    lcg_state     = 95871;
    int             gap;                     // Cycles before the next out_credit

    target_finder_top #(
        .PIX_FIFO_DEPTH(PIX_DEPTH)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .out_credit(out_credit),
        .in_beat(in_beat),
        .in_credit(in_credit),
        .out_valid(out_valid),
        .out_report(out_report)
    );

    function automatic int unsigned lcg_step(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string field, input int got, input int expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                                        $time, field, got, expected));
        end
    endtask

    // Comment lines start with a lone # token
    task automatic load_trace();
        int             fd;
        int             n;
        int             a0, a1, a2, a3, a4, a5;
        logic           done;
        string          tag;
        string          rest;
        pixel_beat_t    beat;
        target_report_t rep;
        done = 1'b0;
        fd   = $fopen("tests/target_trace.txt", "r");
        if (fd == 0) stop_with_failure("could not open tests/target_trace.txt");
        while (!done) begin
            n = $fscanf(fd, "%s", tag);
            if (n != 1) begin
                done = 1'b1;  // End of file
            end else if (tag == "#") begin
                n = $fgets(rest, fd);
            end else if (tag == "P" || tag == "R") begin
                n = $fscanf(fd, "%d %d %d %d %d %d", a0, a1, a2, a3, a4, a5);
                if (n != 6) stop_with_failure({"trace line ", tag, " has too few fields"});
                trace_lines++;
                if (tag == "P") begin
                    beat = '{r: a0, g: a1, b: a2, sof: a3, eol: a4, eof: a5};
                    pix_q.push_back(beat);
                end else begin
                    rep = '{cls: color_class_e'(a0), count: a1, x_min: a2,
                            x_max: a3, y_min: a4, y_max: a5};
                    exp_q.push_back(rep);
                end
            end else begin
                stop_with_failure({"trace holds an unknown record tag ", tag});
            end
        end
        $fclose(fd);
    endtask

    task automatic compare_report(input target_report_t got);
        target_report_t exp;
        string          idx;
        if (exp_q.size() == 0) begin
            stop_with_failure($sformatf("report of class %0d at %0t ns was not expected",
                                        int'(got.cls), $time));
        end
        exp = exp_q.pop_front();
        idx = $sformatf("report %0d", reports_done);
        check_value({idx, " cls"}, int'(got.cls), int'(exp.cls));
        check_value({idx, " count"}, got.count, exp.count);
        check_value({idx, " x_min"}, got.x_min, exp.x_min);
        check_value({idx, " x_max"}, got.x_max, exp.x_max);
        check_value({idx, " y_min"}, got.y_min, exp.y_min);
        check_value({idx, " y_max"}, got.y_max, exp.y_max);
        reports_done++;
        reports_left--;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // Outputs sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (in_credit === 1'b1) begin
            pix_credits   = pix_credits + 1;  // Credit back to the source
            credit_pulses = credit_pulses + 1;
        end
        if (out_valid === 1'b1) begin
            compare_report(out_report);
            owed = owed + 1;
        end
    end

    // Downstream sink, returns each credit after a pseudo-random wait
    initial begin
        out_credit = 1'b0;
        lcg_state  = lcg_step(lcg_state);
        gap        = (lcg_state >> 16) & 7;
        forever begin
            @(posedge clk);
            #2;
            out_credit = 1'b0;
            if (owed > 0) begin
                if (gap == 0) begin
                    out_credit = 1'b1;
                    owed       = owed - 1;
                    lcg_state  = lcg_step(lcg_state);
                    gap        = (lcg_state >> 16) & 7;  // 0 to 7 cycles
                end else begin
                    gap = gap - 1;
                end
            end
        end
    end

    initial begin
        wait (trace_loaded);
        repeat (200 + 20 * trace_lines) @(posedge clk);
        stop_with_failure($sformatf("timeout: %0d expected reports never arrived",
                                    reports_left));
    end

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_beat  = '0;
        load_trace();
        reports_left = exp_q.size();
        trace_loaded = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (pix_q[i]) begin
            @(posedge clk);
            #2;
            while (pix_credits == 0) begin  // Source idles without a credit
                in_valid = 1'b0;
                @(posedge clk);
                #2;
            end
            in_valid    = 1'b1;
            in_beat     = pix_q[i];
            pix_credits = pix_credits - 1;
            beats_sent++;
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        wait (reports_left == 0);
        repeat (QUIET_CYCLES) @(posedge clk);  // Any extra report fails in the monitor
        check_value("in_credit pulses", credit_pulses, beats_sent);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/target_finder_top.sv
`timescale 1ns/10ps
`default_nettype none

module target_finder_top #(
    parameter int                         PIX_FIFO_DEPTH    = 8,
    parameter int                         REPORT_FIFO_DEPTH = 4,
    parameter int                         OUT_CREDITS       = 2,
    parameter vision_pkg::threshold_set_t THRESHOLDS        = vision_pkg::default_thresholds
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic                       out_credit,
    input  vision_pkg::pixel_beat_t    in_beat,
    output logic                       in_credit,
    output logic                       out_valid,
    output vision_pkg::target_report_t out_report
);

    import vision_pkg::*;

    logic             pix_valid;
    logic             stall;      // Only back-pressure into the pixel path
    logic             cls_valid;
    logic             rpt_valid;
    logic             rpt_ready;
    pixel_beat_t      pix_beat;
    classified_beat_t cls_beat;
    target_report_t   rpt;

    pixel_ingress #(
        .PIX_FIFO_DEPTH(PIX_FIFO_DEPTH)
    ) u_ingress (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .stall(stall),
        .in_beat(in_beat),
        .in_credit(in_credit),
        .pix_valid(pix_valid),
        .pix_beat(pix_beat)
    );

    color_classifier #(
        .THRESHOLDS(THRESHOLDS)
    ) u_classifier (
        .clk(clk),
        .rst(rst),
        .pix_valid(pix_valid),
        .stall(stall),
        .pix_beat(pix_beat),
        .cls_valid(cls_valid),
        .cls_beat(cls_beat)
    );

    target_accumulator u_accumulator (
        .clk(clk),
        .rst(rst),
        .cls_valid(cls_valid),
        .rpt_ready(rpt_ready),
        .cls_beat(cls_beat),
        .stall(stall),
        .rpt_valid(rpt_valid),
        .rpt(rpt)
    );

    report_egress #(
        .REPORT_FIFO_DEPTH(REPORT_FIFO_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) u_egress (
        .clk(clk),
        .rst(rst),
        .rpt_valid(rpt_valid),
        .out_credit(out_credit),
        .rpt(rpt),
        .rpt_ready(rpt_ready),
        .out_valid(out_valid),
        .out_report(out_report)
    );

endmodule

`default_nettype wire

// File: src/report_egress.sv
`timescale 1ns/10ps
`default_nettype none

module report_egress #(
    parameter int REPORT_FIFO_DEPTH = 4,
    parameter int OUT_CREDITS       = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rpt_valid,
    input  logic                       out_credit,  // Credit return from downstream
    input  vision_pkg::target_report_t rpt,
    output logic                       rpt_ready,
    output logic                       out_valid,
    output vision_pkg::target_report_t out_report
);

    import vision_pkg::*;

    localparam int PTR_W  = (REPORT_FIFO_DEPTH > 1) ? $clog2(REPORT_FIFO_DEPTH) : 1;
    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    target_report_t    mem [REPORT_FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    fill;
    logic [CRED_W-1:0] credits;  // Reports the downstream can still accept
    logic              push;
    logic              send;

    assign rpt_ready = (fill != (PTR_W+1)'(REPORT_FIFO_DEPTH));  // Free slot left
    assign push      = rpt_valid && rpt_ready;
    assign send      = (fill != '0) && (credits != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rpt;
        end
        if (send) begin
            out_report <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            credits   <= CRED_W'(OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;  // Single-cycle strobe per report
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(REPORT_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == PTR_W'(REPORT_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, send})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            case ({send, out_credit})
                2'b10:   credits <= credits - 1'b1;  // Spent on a report
                2'b01:   credits <= credits + 1'b1;  // Returned
                default: credits <= credits;
            endcase
        end
    end

    // Downstream returns no more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= CRED_W'(OUT_CREDITS))
        else $error("report_egress: credit counter above OUT_CREDITS");

endmodule

`default_nettype wire

// File: src/target_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

module target_accumulator (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cls_valid,
    input  logic                         rpt_ready,  // Report FIFO has room
    input  vision_pkg::classified_beat_t cls_beat,
    output logic                         stall,
    output logic                         rpt_valid,
    output vision_pkg::target_report_t   rpt
);

    import vision_pkg::*;

    typedef enum logic {dump_idle, dump_scan} dump_state_e;

    typedef struct packed {
        logic [COUNT_W-1:0] count;
        logic [COORD_W-1:0] x_min;
        logic [COORD_W-1:0] x_max;
        logic [COORD_W-1:0] y_min;
        logic [COORD_W-1:0] y_max;
    } class_stats_t;

    // Inverted box so the first pixel sets both limits
    localparam class_stats_t EMPTY_STATS = '{count: '0, x_min: '1, x_max: '0,
                                             y_min: '1, y_max: '0};

    class_stats_t       live [NUM_CLASSES];  // Tables of the frame in progress
    class_stats_t       nxt  [NUM_CLASSES];
    class_stats_t       snap [NUM_CLASSES];  // Finished frame being dumped
    class_stats_t       grow;
    class_stats_t       cur;
    dump_state_e        state;
    color_class_e       scan_cls;            // Class offered by the dump
    logic [COORD_W-1:0] x_q;                 // Coordinates of the next pixel
    logic [COORD_W-1:0] y_q;
    logic [COORD_W-1:0] pix_x;
    logic [COORD_W-1:0] pix_y;
    logic               take;
    logic               snap_take;

    // Hold the eof beat until the previous dump has drained
    assign stall     = (state == dump_scan) && cls_valid && cls_beat.eof;
    assign take      = cls_valid && !stall;
    assign snap_take = take && cls_beat.eof;

    assign pix_x = cls_beat.sof ? '0 : x_q;  // sof pixel sits at (0,0)
    assign pix_y = cls_beat.sof ? '0 : y_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            x_q <= '0;
            y_q <= '0;
        end else if (take) begin
            x_q <= cls_beat.eol ? '0 : pix_x + 1'b1;  // Wrap to next line on eol
            y_q <= cls_beat.eol ? pix_y + 1'b1 : pix_y;
        end
    end

    always_comb begin
        nxt  = live;
        grow = live[cls_beat.cls];
        if (take && (cls_beat.cls != cls_none)) begin
            grow.count = grow.count + 1'b1;
            if (pix_x < grow.x_min) grow.x_min = pix_x;
            if (pix_x > grow.x_max) grow.x_max = pix_x;
            if (pix_y < grow.y_min) grow.y_min = pix_y;
            if (pix_y > grow.y_max) grow.y_max = pix_y;
            nxt[cls_beat.cls] = grow;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            live <= '{default: EMPTY_STATS};
            snap <= '{default: EMPTY_STATS};
        end else if (snap_take) begin
            snap <= nxt;  // Includes the eof pixel itself
            live <= '{default: EMPTY_STATS};
        end else if (take) begin
            live <= nxt;
        end
    end

    always_comb begin
        cur       = snap[scan_cls];
        rpt_valid = (state == dump_scan) && (cur.count != '0);  // Empty classes skipped
        rpt.cls   = scan_cls;
        rpt.count = cur.count;
        rpt.x_min = cur.x_min;
        rpt.x_max = cur.x_max;
        rpt.y_min = cur.y_min;
        rpt.y_max = cur.y_max;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= dump_idle;
            scan_cls <= cls_orange;
        end else begin
            case (state)
                dump_idle: begin
                    if (snap_take) begin
                        state    <= dump_scan;
                        scan_cls <= cls_orange;
                    end
                end
                dump_scan: begin
                    // Step on when the class is empty or its report was taken
                    if (!rpt_valid || rpt_ready) begin
                        if (scan_cls == cls_green) state <= dump_idle;
                        else scan_cls <= color_class_e'(scan_cls + 3'd1);
                    end
                end
                default: state <= dump_idle;
            endcase
        end
    end

    // Snapshot stays frozen while any of its reports is still being offered
    a_snap_idle: assert property (@(posedge clk) disable iff (rst)
        (state == dump_scan) |=>
            $stable(snap[0]) && $stable(snap[1]) && $stable(snap[2]) &&
            $stable(snap[3]) && $stable(snap[4]))
        else $error("target_accumulator: snapshot taken during a dump");

    a_no_wrap: assert property (@(posedge clk) disable iff (rst)
        take && (cls_beat.cls != cls_none) |-> (live[cls_beat.cls].count != '1))
        else $error("target_accumulator: pixel count would wrap");

endmodule

`default_nettype wire

// File: src/color_classifier.sv
`timescale 1ns/10ps
`default_nettype none

module color_classifier #(
    parameter vision_pkg::threshold_set_t THRESHOLDS = vision_pkg::default_thresholds
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pix_valid,
    input  logic                         stall,
    input  vision_pkg::pixel_beat_t      pix_beat,
    output logic                         cls_valid,
    output vision_pkg::classified_beat_t cls_beat
);

    import vision_pkg::*;

    logic         hit_orange;
    logic         hit_pink;
    logic         hit_purple;
    logic         hit_blue;
    logic         hit_green;
    color_class_e pick;  // Winning class for this pixel

    // Both limits inclusive on every channel
    function automatic logic in_window(pixel_beat_t p, color_window_t w);
        return (p.r >= w.r_min) && (p.r <= w.r_max) &&
               (p.g >= w.g_min) && (p.g <= w.g_max) &&
               (p.b >= w.b_min) && (p.b <= w.b_max);
    endfunction

    assign hit_orange = in_window(pix_beat, THRESHOLDS.orange);
    assign hit_pink   = in_window(pix_beat, THRESHOLDS.pink);
    assign hit_purple = in_window(pix_beat, THRESHOLDS.purple);
    assign hit_blue   = in_window(pix_beat, THRESHOLDS.blue);
    assign hit_green  = in_window(pix_beat, THRESHOLDS.green);

    // Windows may overlap, enum order decides
    always_comb begin
        if (hit_orange) begin
            pick = cls_orange;
        end else if (hit_pink) begin
            pick = cls_pink;
        end else if (hit_purple) begin
            pick = cls_purple;
        end else if (hit_blue) begin
            pick = cls_blue;
        end else if (hit_green) begin
            pick = cls_green;
        end else begin
            pick = cls_none;  // Background pixel
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cls_valid <= 1'b0;
        end else if (!stall) begin
            cls_valid <= pix_valid;  // Held while stalled
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (pix_valid && !stall) begin
            cls_beat.cls <= pick;
            cls_beat.sof <= pix_beat.sof;
            cls_beat.eol <= pix_beat.eol;
            cls_beat.eof <= pix_beat.eof;
        end
    end

endmodule

`default_nettype wire

// File: src/pixel_ingress.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_ingress #(
    parameter int PIX_FIFO_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic                    stall,      // Back-pressure from accumulator
    input  vision_pkg::pixel_beat_t in_beat,
    output logic                    in_credit,  // One pulse per pop
    output logic                    pix_valid,
    output vision_pkg::pixel_beat_t pix_beat
);

    import vision_pkg::*;

    localparam int PTR_W = (PIX_FIFO_DEPTH > 1) ? $clog2(PIX_FIFO_DEPTH) : 1;

    pixel_beat_t      mem [PIX_FIFO_DEPTH];  // Beat storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;                  // Beats held
    logic             fifo_empty;
    logic             fifo_full;
    logic             push;
    logic             pop;

    assign fifo_empty = (fill == '0);
    assign fifo_full  = (fill == (PTR_W+1)'(PIX_FIFO_DEPTH));
    assign push       = in_valid && !fifo_full;  // Upstream only sends with credit
    assign pop        = !fifo_empty && !stall;

    // Fall-through read, popped beat is visible in the pop cycle
    assign pix_valid = pop;
    assign pix_beat  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            in_credit <= 1'b0;
        end else begin
            in_credit <= pop;  // Credit back to the source
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(PIX_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(PIX_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;  // Idle or simultaneous push and pop
            endcase
        end
    end

    // Source must never send without a credit
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> !fifo_full)
        else $error("pixel_ingress: beat arrived with FIFO full");

endmodule

`default_nettype wire

// File: src/vision_pkg.sv
`default_nettype none

package vision_pkg;

    localparam int COORD_W     = 10;  // x and y coordinate width
    localparam int COUNT_W     = 16;  // Per-class pixel count width
    localparam int NUM_CLASSES = 5;   // Real colour classes, cls_none excluded

    // Priority order, first match wins
    typedef enum logic [2:0] {
        cls_orange,
        cls_pink,
        cls_purple,
        cls_blue,
        cls_green,
        cls_none
    } color_class_e;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        logic       sof;  // First pixel of frame
        logic       eol;  // Last pixel of line
        logic       eof;  // Last pixel of frame
    } pixel_beat_t;

    typedef struct packed {
        color_class_e cls;
        logic         sof;
        logic         eol;
        logic         eof;
    } classified_beat_t;

    // Inclusive limits per channel
    typedef struct packed {
        logic [3:0] r_min;
        logic [3:0] r_max;
        logic [3:0] g_min;
        logic [3:0] g_max;
        logic [3:0] b_min;
        logic [3:0] b_max;
    } color_window_t;

    typedef struct packed {
        color_window_t orange;
        color_window_t pink;
        color_window_t purple;
        color_window_t blue;
        color_window_t green;
    } threshold_set_t;

    // Open sides of a window sit at 0 or 15
    localparam threshold_set_t default_thresholds = '{
        orange: '{r_min: 4'd8,  r_max: 4'd15, g_min: 4'd2,  g_max: 4'd5,
                  b_min: 4'd0,  b_max: 4'd5},
        pink:   '{r_min: 4'd12, r_max: 4'd15, g_min: 4'd0,  g_max: 4'd3,
                  b_min: 4'd10, b_max: 4'd15},
        purple: '{r_min: 4'd6,  r_max: 4'd10, g_min: 4'd0,  g_max: 4'd3,
                  b_min: 4'd6,  b_max: 4'd10},
        blue:   '{r_min: 4'd0,  r_max: 4'd3,  g_min: 4'd0,  g_max: 4'd7,
                  b_min: 4'd10, b_max: 4'd15},
        green:  '{r_min: 4'd0,  r_max: 4'd4,  g_min: 4'd10, g_max: 4'd15,
                  b_min: 4'd0,  b_max: 4'd4}
    };

    typedef struct packed {
        color_class_e       cls;
        logic [COUNT_W-1:0] count;
        logic [COORD_W-1:0] x_min;
        logic [COORD_W-1:0] x_max;
        logic [COORD_W-1:0] y_min;
        logic [COORD_W-1:0] y_max;
    } target_report_t;

endpackage

`default_nettype wire
